// ==== rtl/bag_msg_consts.svh ====
`ifndef BAG_MSG_CONSTS_SVH
`define BAG_MSG_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////
`define BYTE_W      8
`define BCD_W       4
`define LEVEL_W     9
`define STAGE_W     3
`define RECORD_W    28
`define IDX_W       6     // byte index, longest message fits

// stored log record layout, lsb of each field
`define REC_LEVEL_LSB  19
`define REC_STAGE_LSB  16
`define REC_MIN_LSB    12
`define REC_DMIN_LSB   8
`define REC_HOUR_LSB   4
`define REC_DHOUR_LSB  0

// level is printed only for multiples of the step up to the max
`define LEVEL_MAX   500
`define LEVEL_STEP  5

//////////////////////////////////////////////////////////////////////
// message lengths, LF and CR included
//////////////////////////////////////////////////////////////////////
`define LEN_BAG_INC 32
`define LEN_ALARM   62
`define LEN_LOG     13

// character codes
`define ASCII_ZERO  8'h30
`define ASCII_SPACE 8'h20
`define ASCII_COLON 8'h3A
`define ASCII_LF    8'h0A
`define ASCII_CR    8'h0D

`endif

// ==== rtl/bag_msg_pkg.sv ====
package bag_msg_pkg;

   // ids as used by the monitor firmware
   typedef enum logic [2:0] {
      MSG_NONE    = 3'd0,
      MSG_BAG_INC = 3'd1,
      MSG_ALARM   = 3'd3,
      MSG_LOG     = 3'd6
   } msg_id_t;

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOAD,   // digits settle
      S_SEND
   } seq_state_t;

endpackage

// ==== rtl/msg_request.sv ====
`include "bag_msg_consts.svh"

module msg_request
   import bag_msg_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  msg_id_t               req_id,
   input  logic [`LEVEL_W-1:0]   level,
   input  logic [`STAGE_W-1:0]   stage,
   input  logic [`BCD_W-1:0]     dhours,
   input  logic [`BCD_W-1:0]     hours,
   input  logic [`BCD_W-1:0]     dminutes,
   input  logic [`BCD_W-1:0]     minutes,
   input  logic [`RECORD_W-1:0]  log_record,
   input  logic                  done,
   output logic                  req_ready,
   output logic                  start,
   output msg_id_t               msg_id,
   output logic [`LEVEL_W-1:0]   f_level,
   output logic [`STAGE_W-1:0]   f_stage,
   output logic [`BCD_W-1:0]     f_dhours,
   output logic [`BCD_W-1:0]     f_hours,
   output logic [`BCD_W-1:0]     f_dminutes,
   output logic [`BCD_W-1:0]     f_minutes
);

   logic busy;
   logic accept;

   assign req_ready = ~busy;
   assign accept    = req_valid & req_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy   <= 1'b0;
         start  <= 1'b0;
         msg_id <= MSG_NONE;
      end else begin
         start <= accept;
         if (accept) begin
            busy   <= 1'b1;
            msg_id <= req_id;
         end else if (done) begin
            busy <= 1'b0;                      // ready again next cycle
         end
      end
   end

   // field capture, log record unpacked here
   always_ff @(posedge clk) begin
      if (accept) begin
         if (req_id == MSG_LOG) begin
            f_level    <= log_record[`REC_LEVEL_LSB +: `LEVEL_W];
            f_stage    <= log_record[`REC_STAGE_LSB +: `STAGE_W];
            f_dhours   <= log_record[`REC_DHOUR_LSB +: `BCD_W];
            f_hours    <= log_record[`REC_HOUR_LSB +: `BCD_W];
            f_dminutes <= log_record[`REC_DMIN_LSB +: `BCD_W];
            f_minutes  <= log_record[`REC_MIN_LSB +: `BCD_W];
         end else begin
            f_level    <= level;
            f_stage    <= stage;
            f_dhours   <= dhours;
            f_hours    <= hours;
            f_dminutes <= dminutes;
            f_minutes  <= minutes;
         end
      end
   end

endmodule

// ==== rtl/field_ascii.sv ====
`include "bag_msg_consts.svh"

module field_ascii (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  logic [`LEVEL_W-1:0]   f_level,
   input  logic [`STAGE_W-1:0]   f_stage,
   input  logic [`BCD_W-1:0]     f_dhours,
   input  logic [`BCD_W-1:0]     f_hours,
   input  logic [`BCD_W-1:0]     f_dminutes,
   input  logic [`BCD_W-1:0]     f_minutes,
   output logic [`BYTE_W-1:0]    a_lvl_h,
   output logic [`BYTE_W-1:0]    a_lvl_t,
   output logic [`BYTE_W-1:0]    a_lvl_u,
   output logic [`BYTE_W-1:0]    a_stage,
   output logic [`BYTE_W-1:0]    a_dhours,
   output logic [`BYTE_W-1:0]    a_hours,
   output logic [`BYTE_W-1:0]    a_dminutes,
   output logic [`BYTE_W-1:0]    a_minutes
);

   logic                lvl_ok;
   logic [`BCD_W-1:0]   lvl_h;
   logic [`BCD_W-1:0]   lvl_t;
   logic [`BCD_W-1:0]   lvl_u;

   // one decimal digit, nul when above its limit
   function automatic logic [`BYTE_W-1:0] digit_ascii(input logic [`BCD_W-1:0] value,
                                                     input logic [`BCD_W-1:0] max_value);
      if (value <= max_value)
         return `ASCII_ZERO + `BYTE_W'(value);
      return '0;
   endfunction

   always_comb begin
      lvl_ok = (f_level <= `LEVEL_MAX) && ((f_level % `LEVEL_STEP) == 0);
      lvl_h  = `BCD_W'(f_level / 100);
      lvl_t  = `BCD_W'((f_level / 10) % 10);
      lvl_u  = `BCD_W'(f_level % 10);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         a_lvl_h    <= '0;
         a_lvl_t    <= '0;
         a_lvl_u    <= '0;
         a_stage    <= '0;
         a_dhours   <= '0;
         a_hours    <= '0;
         a_dminutes <= '0;
         a_minutes  <= '0;
      end else if (start) begin
         a_lvl_h    <= lvl_ok ? `ASCII_ZERO + `BYTE_W'(lvl_h) : '0;
         a_lvl_t    <= lvl_ok ? `ASCII_ZERO + `BYTE_W'(lvl_t) : '0;
         a_lvl_u    <= lvl_ok ? `ASCII_ZERO + `BYTE_W'(lvl_u) : '0;
         a_stage    <= digit_ascii(`BCD_W'(f_stage), 4'd5);
         a_dhours   <= digit_ascii(f_dhours, 4'd2);     // 00..29 on the clock
         a_hours    <= digit_ascii(f_hours, 4'd9);
         a_dminutes <= digit_ascii(f_dminutes, 4'd5);
         a_minutes  <= digit_ascii(f_minutes, 4'd9);
      end
   end

endmodule

// ==== rtl/msg_text_rom.sv ====
`include "bag_msg_consts.svh"

module msg_text_rom
   import bag_msg_pkg::*;
(
   input  msg_id_t               msg_id,
   input  logic [`IDX_W-1:0]     idx,
   input  logic [`BYTE_W-1:0]    a_lvl_h,
   input  logic [`BYTE_W-1:0]    a_lvl_t,
   input  logic [`BYTE_W-1:0]    a_lvl_u,
   input  logic [`BYTE_W-1:0]    a_stage,
   input  logic [`BYTE_W-1:0]    a_dhours,
   input  logic [`BYTE_W-1:0]    a_hours,
   input  logic [`BYTE_W-1:0]    a_dminutes,
   input  logic [`BYTE_W-1:0]    a_minutes,
   output logic [`BYTE_W-1:0]    data,
   output logic                  last
);

   //////////////////////////////////////////////////////////////////////
   // fixed texts, left aligned in a field as wide as the longest one
   //////////////////////////////////////////////////////////////////////
   localparam int TXT_W = `BYTE_W * `LEN_ALARM;

   localparam logic [TXT_W-1:0] BAG_TXT = {
      "the value of the bag increased",
      `ASCII_LF, `ASCII_CR,
      {(`BYTE_W * (`LEN_ALARM - `LEN_BAG_INC)){1'b0}}
   };

   // dashes mark the digit slots
   localparam logic [TXT_W-1:0] ALARM_TXT = {
      "alarm on:the drainage level is ",
      "---",
      " in stage ",
      "-",
      " at hour ",
      "--:-- ",
      `ASCII_LF, `ASCII_CR
   };

   function automatic logic [`BYTE_W-1:0] text_byte(input logic [TXT_W-1:0] txt,
                                                   input logic [`IDX_W-1:0] i);
      return txt[`BYTE_W * (`LEN_ALARM - 1 - i) +: `BYTE_W];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // byte select
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      data = '0;
      last = 1'b0;
      case (msg_id)
         MSG_BAG_INC: begin
            if (idx < `LEN_BAG_INC)
               data = text_byte(BAG_TXT, idx);
            last = (idx == `LEN_BAG_INC - 1);
         end
         MSG_ALARM: begin
            if (idx < `LEN_ALARM)
               data = text_byte(ALARM_TXT, idx);
            case (idx)
               6'd31: data = a_lvl_h;
               6'd32: data = a_lvl_t;
               6'd33: data = a_lvl_u;
               6'd44: data = a_stage;
               6'd54: data = a_dhours;
               6'd55: data = a_hours;
               6'd57: data = a_dminutes;
               6'd58: data = a_minutes;
               default: ;                           // keep text
            endcase
            last = (idx == `LEN_ALARM - 1);
         end
         MSG_LOG: begin
            case (idx)
               6'd0:  data = a_lvl_h;
               6'd1:  data = a_lvl_t;
               6'd2:  data = a_lvl_u;
               6'd3:  data = `ASCII_SPACE;
               6'd4:  data = a_stage;
               6'd5:  data = `ASCII_SPACE;
               6'd6:  data = a_dhours;
               6'd7:  data = a_hours;
               6'd8:  data = `ASCII_COLON;
               6'd9:  data = a_dminutes;
               6'd10: data = a_minutes;
               6'd11: data = `ASCII_LF;
               6'd12: data = `ASCII_CR;
               default: data = '0;
            endcase
            last = (idx == `LEN_LOG - 1);
         end
         default: ;                                 // no text for other ids
      endcase
   end

endmodule

// ==== rtl/msg_sequencer.sv ====
`include "bag_msg_consts.svh"

module msg_sequencer
   import bag_msg_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  msg_id_t               msg_id,
   input  logic [`BYTE_W-1:0]    rom_data,
   input  logic                  rom_last,
   input  logic                  full,
   output logic [`IDX_W-1:0]     idx,
   output logic                  push,
   output logic [`BYTE_W-1:0]    push_data,
   output logic                  push_last,
   output logic                  done
);

   seq_state_t state;
   logic       has_text;
   logic       pushed;

   always_comb begin
      case (msg_id)
         MSG_BAG_INC, MSG_ALARM, MSG_LOG: has_text = 1'b1;
         default:                         has_text = 1'b0;
      endcase
   end

   assign push      = (state == S_SEND);
   assign push_data = rom_data;
   assign push_last = rom_last;
   assign pushed    = push & ~full;

   // last byte taken, or nothing to send
   assign done = (pushed & rom_last) | ((state == S_LOAD) & ~has_text);

   //////////////////////////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (start) begin
                  state <= S_LOAD;
                  idx   <= '0;
               end
            end
            S_LOAD: begin
               state <= has_text ? S_SEND : S_IDLE;
            end
            S_SEND: begin
               if (pushed) begin
                  idx <= idx + 1'b1;
                  if (rom_last)
                     state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// ==== rtl/byte_out_fifo.sv ====
`include "bag_msg_consts.svh"

module byte_out_fifo (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  push,
   input  logic [`BYTE_W-1:0]    push_data,
   input  logic                  push_last,
   input  logic                  byte_ready,
   output logic                  full,
   output logic [`BYTE_W-1:0]    byte_data,
   output logic                  byte_valid,
   output logic                  byte_last
);

   logic [`BYTE_W-1:0]  data_mem [2];
   logic                last_mem [2];
   logic                wr_ptr;
   logic                rd_ptr;
   logic [1:0]          count;
   logic                do_push;
   logic                do_pop;

   assign full       = (count == 2'd2);
   assign byte_valid = (count != 2'd0);
   assign do_push    = push & ~full;
   assign do_pop     = byte_valid & byte_ready;

   assign byte_data  = data_mem[rd_ptr];
   assign byte_last  = byte_valid & last_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (do_push)
            wr_ptr <= ~wr_ptr;
         if (do_pop)
            rd_ptr <= ~rd_ptr;
         case ({do_push, do_pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: ;                       // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         data_mem[wr_ptr] <= push_data;
         last_mem[wr_ptr] <= push_last;
      end
   end

endmodule

// ==== rtl/bag_msg_encoder.sv ====
`include "bag_msg_consts.svh"

module bag_msg_encoder
   import bag_msg_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  msg_id_t               req_id,
   input  logic [`LEVEL_W-1:0]   level,
   input  logic [`STAGE_W-1:0]   stage,
   input  logic [`BCD_W-1:0]     dhours,
   input  logic [`BCD_W-1:0]     hours,
   input  logic [`BCD_W-1:0]     dminutes,
   input  logic [`BCD_W-1:0]     minutes,
   input  logic [`RECORD_W-1:0]  log_record,
   output logic [`BYTE_W-1:0]    byte_data,
   output logic                  byte_valid,
   input  logic                  byte_ready,
   output logic                  byte_last
);

   logic                start;
   logic                done;
   msg_id_t             msg_id;
   logic [`LEVEL_W-1:0] f_level;
   logic [`STAGE_W-1:0] f_stage;
   logic [`BCD_W-1:0]   f_dhours;
   logic [`BCD_W-1:0]   f_hours;
   logic [`BCD_W-1:0]   f_dminutes;
   logic [`BCD_W-1:0]   f_minutes;
   logic [`BYTE_W-1:0]  a_lvl_h;
   logic [`BYTE_W-1:0]  a_lvl_t;
   logic [`BYTE_W-1:0]  a_lvl_u;
   logic [`BYTE_W-1:0]  a_stage;
   logic [`BYTE_W-1:0]  a_dhours;
   logic [`BYTE_W-1:0]  a_hours;
   logic [`BYTE_W-1:0]  a_dminutes;
   logic [`BYTE_W-1:0]  a_minutes;
   logic [`IDX_W-1:0]   idx;
   logic [`BYTE_W-1:0]  rom_data;
   logic                rom_last;
   logic                push;
   logic [`BYTE_W-1:0]  push_data;
   logic                push_last;
   logic                full;

   //////////////////////////////////////////////////////////////////////
   // request side and digit conversion
   //////////////////////////////////////////////////////////////////////
   msg_request u_request (
      .clk, .rst_n, .req_valid, .req_id, .level, .stage, .dhours, .hours,
      .dminutes, .minutes, .log_record, .done, .req_ready, .start, .msg_id,
      .f_level, .f_stage, .f_dhours, .f_hours, .f_dminutes, .f_minutes
   );

   field_ascii u_ascii (
      .clk, .rst_n, .start, .f_level, .f_stage, .f_dhours, .f_hours,
      .f_dminutes, .f_minutes, .a_lvl_h, .a_lvl_t, .a_lvl_u, .a_stage,
      .a_dhours, .a_hours, .a_dminutes, .a_minutes
   );

   //////////////////////////////////////////////////////////////////////
   // byte generation and output buffer
   //////////////////////////////////////////////////////////////////////
   msg_text_rom u_rom (
      .msg_id, .idx, .a_lvl_h, .a_lvl_t, .a_lvl_u, .a_stage, .a_dhours,
      .a_hours, .a_dminutes, .a_minutes, .data(rom_data), .last(rom_last)
   );

   msg_sequencer u_seq (
      .clk, .rst_n, .start, .msg_id, .rom_data, .rom_last, .full,
      .idx, .push, .push_data, .push_last, .done
   );

   byte_out_fifo u_fifo (
      .clk, .rst_n, .push, .push_data, .push_last, .byte_ready,
      .full, .byte_data, .byte_valid, .byte_last
   );

endmodule

// ==== tb/bag_msg_model.svh ====
`ifndef BAG_MSG_MODEL_SVH
`define BAG_MSG_MODEL_SVH

`include "bag_msg_consts.svh"

function automatic void push_byte(input logic [7:0] b, input logic lst);
   exp_data.push_back(b);
   exp_last.push_back(lst);
   total_bytes++;
endfunction

function automatic void push_text(input string txt);
   for (int i = 0; i < txt.len(); i++)
      push_byte(txt[i], 1'b0);
endfunction

// single digit, nul above the limit
function automatic logic [7:0] ascii_digit(input int value, input int max_value);
   return (value <= max_value) ? `ASCII_ZERO + 8'(value) : 8'h00;
endfunction

function automatic void push_level(input int lvl);
   if (lvl <= `LEVEL_MAX && (lvl % `LEVEL_STEP) == 0) begin
      push_byte(ascii_digit(lvl / 100, 9), 1'b0);
      push_byte(ascii_digit((lvl / 10) % 10, 9), 1'b0);
      push_byte(ascii_digit(lvl % 10, 9), 1'b0);
   end else begin
      repeat (3) push_byte(8'h00, 1'b0);
   end
endfunction

function automatic void push_time(input int dh, input int h, input int dm, input int m);
   push_byte(ascii_digit(dh, 2), 1'b0);
   push_byte(ascii_digit(h, 9), 1'b0);
   push_byte(`ASCII_COLON, 1'b0);
   push_byte(ascii_digit(dm, 5), 1'b0);
   push_byte(ascii_digit(m, 9), 1'b0);
endfunction

function automatic void push_line_end();
   push_byte(`ASCII_LF, 1'b0);
   push_byte(`ASCII_CR, 1'b1);       // last byte of every message
endfunction

function automatic void expect_request(input msg_id_t id, input int lvl, input int stg,
                                       input int dh, input int h, input int dm,
                                       input int m, input logic [`RECORD_W-1:0] rec);
   case (id)
      MSG_BAG_INC: begin
         push_text("the value of the bag increased");
         push_line_end();
      end
      MSG_ALARM: begin
         push_text("alarm on:the drainage level is ");
         push_level(lvl);
         push_text(" in stage ");
         push_byte(ascii_digit(stg, 5), 1'b0);
         push_text(" at hour ");
         push_time(dh, h, dm, m);
         push_byte(`ASCII_SPACE, 1'b0);
         push_line_end();
      end
      MSG_LOG: begin
         push_level(rec[`REC_LEVEL_LSB +: `LEVEL_W]);
         push_byte(`ASCII_SPACE, 1'b0);
         push_byte(ascii_digit(rec[`REC_STAGE_LSB +: `STAGE_W], 5), 1'b0);
         push_byte(`ASCII_SPACE, 1'b0);
         push_time(rec[`REC_DHOUR_LSB +: `BCD_W], rec[`REC_HOUR_LSB +: `BCD_W],
                   rec[`REC_DMIN_LSB +: `BCD_W], rec[`REC_MIN_LSB +: `BCD_W]);
         push_line_end();
      end
      default: ;                       // no bytes
   endcase
endfunction

`endif

// ==== tb/bag_msg_encoder_tb.sv ====
`include "bag_msg_consts.svh"

module bag_msg_encoder_tb
   import bag_msg_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic                  clk = 1'b0;
   logic                  rst_n = 1'b0;
   logic                  req_valid = 1'b0;
   logic                  req_ready;
   msg_id_t               req_id = MSG_NONE;
   logic [`LEVEL_W-1:0]   level = '0;
   logic [`STAGE_W-1:0]   stage = '0;
   logic [`BCD_W-1:0]     dhours = '0;
   logic [`BCD_W-1:0]     hours = '0;
   logic [`BCD_W-1:0]     dminutes = '0;
   logic [`BCD_W-1:0]     minutes = '0;
   logic [`RECORD_W-1:0]  log_record = '0;
   logic [`BYTE_W-1:0]    byte_data;
   logic                  byte_valid;
   logic                  byte_ready = 1'b1;
   logic                  byte_last;

   logic [7:0]  exp_data [$];
   logic        exp_last [$];
   int          total_bytes = 0;
   int          errors = 0;
   int          cycles = 0;
   bit          rand_ready = 1'b0;
   msg_id_t     ids [4] = '{MSG_NONE, MSG_BAG_INC, MSG_ALARM, MSG_LOG};

   `include "bag_msg_model.svh"

   always #5 clk = ~clk;

   bag_msg_encoder UUT (.*);

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("error %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // call at 1 ns after an edge, returns the same way
   task automatic send_request(input msg_id_t id, input int lvl, input int stg,
                               input int dh, input int h, input int dm, input int m,
                               input logic [`RECORD_W-1:0] rec);
      req_valid  = 1'b1;
      req_id     = id;
      level      = `LEVEL_W'(lvl);
      stage      = `STAGE_W'(stg);
      dhours     = `BCD_W'(dh);
      hours      = `BCD_W'(h);
      dminutes   = `BCD_W'(dm);
      minutes    = `BCD_W'(m);
      log_record = rec;
      @(posedge clk);
      while (!req_ready) @(posedge clk);
      expect_request(id, lvl, stg, dh, h, dm, m, rec);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic send_random(input msg_id_t id, input bit wild_record);
      int lvl, stg, dh, h, dm, m;
      logic [`RECORD_W-1:0] rec;
      lvl = `LEVEL_STEP * ($urandom % 101);
      stg = $urandom % 6;
      dh  = $urandom % 3;
      h   = $urandom % 10;
      dm  = $urandom % 6;
      m   = $urandom % 10;
      if (wild_record)
         rec = `RECORD_W'($urandom);
      else
         rec = {9'(lvl), 3'(stg), 4'(m), 4'(dm), 4'(h), 4'(dh)};
      send_request(id, lvl, stg, dh, h, dm, m, rec);
   endtask

   task automatic wait_drain();
      while (exp_data.size() != 0) @(posedge clk);
      @(posedge clk);
      #1;
   endtask

   //////////////////////////////////////////////////////////////////////
   // output side
   //////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      #1;
      byte_ready = rand_ready ? (($urandom % 4) != 0) : 1'b1;
   end

   always @(posedge clk) begin : collect
      logic [7:0] eb;
      logic       el;
      if (rst_n && byte_valid && byte_ready) begin
         if (exp_data.size() == 0) begin
            $display("byte %h came out while no message was pending", byte_data);
            errors++;
         end else begin
            eb = exp_data.pop_front();
            el = exp_last.pop_front();
            check_value("byte_data", byte_data, eb);
            if (el && !byte_last) begin
               $display("byte_last missing on the final byte of a message");
               errors++;
            end else begin
               check_value("byte_last", byte_last, el);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > 40 * total_bytes + 500) begin
         $display("timeout after %0d cycles, %0d bytes still expected", cycles,
                  exp_data.size());
         $display("errors: %0d", errors + 1);
         $display("Some tests failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'ha3aa_5555));
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;
      @(posedge clk);
      #1;
      check_value("req_ready", req_ready, 1'b1);
      check_value("byte_valid", byte_valid, 1'b0);
      send_request(MSG_BAG_INC, 0, 0, 0, 0, 0, 0, '0);
      wait_drain();
      check_value("byte_valid", byte_valid, 1'b0);
      repeat (4) send_random(MSG_ALARM, 1'b1);
      wait_drain();
      send_request(MSG_ALARM, 7, 6, 3, 1, 2, 12, '0);       // bad digits
      send_request(MSG_ALARM, 505, 2, 1, 4, 3, 9, '0);
      wait_drain();
      for (int i = 0; i < 6; i++)
         send_random(MSG_LOG, i[0]);
      wait_drain();
      rand_ready = 1'b1;                                    // back-pressure
      for (int i = 0; i < 16; i++)
         send_random(ids[i % 4], 1'b1);
      wait_drain();
      rand_ready = 1'b0;
      $display("errors: %0d, bytes checked: %0d", errors, total_bytes);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// ==== bag_msg_encoder.f ====
+incdir+rtl
+incdir+tb
rtl/bag_msg_pkg.sv
rtl/msg_request.sv
rtl/field_ascii.sv
rtl/msg_text_rom.sv
rtl/msg_sequencer.sv
rtl/byte_out_fifo.sv
rtl/bag_msg_encoder.sv
tb/bag_msg_encoder_tb.sv
